/* hdl/fc8_pkg.sv */
// Opcodes, decoded-instruction and flag types, flag constants
package fc8_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // 6502-family encodings for the supported subset
    typedef enum logic [7:0] {
        LDA_IMM = 8'hA9, LDA_ZP  = 8'hA5, LDA_ABS = 8'hAD,
        LDX_IMM = 8'hA2, LDX_ZP  = 8'hA6, LDX_ABS = 8'hAE,
        STA_ZP  = 8'h85, STA_ABS = 8'h8D,
        STX_ZP  = 8'h86,
        ADC_IMM = 8'h69, ADC_ZP  = 8'h65, ADC_ABS = 8'h6D,
        SBC_IMM = 8'hE9, SBC_ZP  = 8'hE5, SBC_ABS = 8'hED,
        AND_IMM = 8'h29, AND_ZP  = 8'h25, AND_ABS = 8'h2D,
        ORA_IMM = 8'h09, ORA_ZP  = 8'h05, ORA_ABS = 8'h0D,
        EOR_IMM = 8'h49, EOR_ZP  = 8'h45, EOR_ABS = 8'h4D,
        CMP_IMM = 8'hC9, CMP_ZP  = 8'hC5, CMP_ABS = 8'hCD,
        INX     = 8'hE8, DEX     = 8'hCA,
        CLC     = 8'h18, SEC     = 8'h38,
        BEQ     = 8'hF0, BNE     = 8'hD0,
        BCC     = 8'h90, BCS     = 8'hB0,
        BMI     = 8'h30, BPL     = 8'h10,
        JMP     = 8'h4C,
        NOP     = 8'hEA,
        HLT     = 8'h02
    } opcode_e;

    typedef enum logic [2:0] {
        MODE_NONE,
        MODE_IMM,
        MODE_ZP,
        MODE_ABS,
        MODE_REL
    } addr_mode_e;

    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CMP,
        ALU_INC,
        ALU_DEC
    } alu_op_e;

    typedef enum logic [1:0] {
        DEST_NONE,
        DEST_A,
        DEST_X
    } dest_e;

    typedef enum logic [2:0] {
        FLOW_NORMAL,
        FLOW_STORE,
        FLOW_BRANCH,
        FLOW_JUMP,
        FLOW_HALT
    } flow_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
    } flags_t;

    // Bit positions inside flags_t
    localparam logic [1:0] FLAG_C = 2'd0;
    localparam logic [1:0] FLAG_Z = 2'd1;
    localparam logic [1:0] FLAG_N = 2'd2;

    typedef struct packed {
        addr_mode_e mode;
        alu_op_e    alu_op;
        dest_e      dest;
        flow_e      flow;
        logic       lhs_x;     // ALU left operand is X
        logic       store_x;   // Store X instead of A
        logic [1:0] br_sel;
        logic       br_pol;    // Branch when selected flag equals this
        logic       flag_set;
        logic       flag_val;
    } decoded_t;

    localparam addr_t RESET_VECTOR_DEFAULT = 16'hFFFC;

endpackage

/* hdl/fc8_exec_if.sv */
// Execute interface between sequencer and register block
`timescale 1ns/1ps

interface fc8_exec_if;
    import fc8_pkg::*;

    decoded_t dec;
    byte_t    operand;
    logic     exec;         // Commit strobe
    flags_t   flags;
    byte_t    store_data;

    modport seq (
        output dec,
        output operand,
        output exec,
        input  flags,
        input  store_data
    );

    modport regs (
        input  dec,
        input  operand,
        input  exec,
        output flags,
        output store_data
    );

endinterface

/* hdl/fc8_decoder.sv */
// Opcode decoder
`timescale 1ns/1ps

module fc8_decoder (
    input  fc8_pkg::byte_t    opcode,
    output fc8_pkg::decoded_t dec
);
    import fc8_pkg::*;

    always_comb begin
        dec = '0;  // Anything not listed runs as NOP

        // Addressing mode
        case (opcode)
            LDA_IMM, LDX_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM, CMP_IMM:
                dec.mode = MODE_IMM;
            LDA_ZP, LDX_ZP, STA_ZP, STX_ZP, ADC_ZP, SBC_ZP, AND_ZP, ORA_ZP, EOR_ZP, CMP_ZP:
                dec.mode = MODE_ZP;
            LDA_ABS, LDX_ABS, STA_ABS, ADC_ABS, SBC_ABS, AND_ABS, ORA_ABS, EOR_ABS,
            CMP_ABS, JMP:
                dec.mode = MODE_ABS;
            BEQ, BNE, BCC, BCS, BMI, BPL: begin
                dec.mode = MODE_REL;
                dec.flow = FLOW_BRANCH;
            end
            default: ;
        endcase

        // Operation and destination
        case (opcode)
            LDA_IMM, LDA_ZP, LDA_ABS: dec.dest = DEST_A;
            LDX_IMM, LDX_ZP, LDX_ABS: dec.dest = DEST_X;
            STA_ZP, STA_ABS:          dec.flow = FLOW_STORE;
            STX_ZP: begin
                dec.flow    = FLOW_STORE;
                dec.store_x = 1'b1;
            end
            ADC_IMM, ADC_ZP, ADC_ABS: begin
                dec.alu_op = ALU_ADD;
                dec.dest   = DEST_A;
            end
            SBC_IMM, SBC_ZP, SBC_ABS: begin
                dec.alu_op = ALU_SUB;
                dec.dest   = DEST_A;
            end
            AND_IMM, AND_ZP, AND_ABS: begin
                dec.alu_op = ALU_AND;
                dec.dest   = DEST_A;
            end
            ORA_IMM, ORA_ZP, ORA_ABS: begin
                dec.alu_op = ALU_OR;
                dec.dest   = DEST_A;
            end
            EOR_IMM, EOR_ZP, EOR_ABS: begin
                dec.alu_op = ALU_XOR;
                dec.dest   = DEST_A;
            end
            CMP_IMM, CMP_ZP, CMP_ABS: dec.alu_op = ALU_CMP;  // Flags only
            INX, DEX: begin
                dec.alu_op = (opcode == INX) ? ALU_INC : ALU_DEC;
                dec.dest   = DEST_X;
                dec.lhs_x  = 1'b1;
            end
            CLC, SEC: begin
                dec.flag_set = 1'b1;
                dec.flag_val = (opcode == SEC);
            end
            JMP:     dec.flow = FLOW_JUMP;
            HLT:     dec.flow = FLOW_HALT;
            default: ;
        endcase

        // Branch condition
        case (opcode)
            BEQ, BNE: dec.br_sel = FLAG_Z;
            BMI, BPL: dec.br_sel = FLAG_N;
            default:  dec.br_sel = FLAG_C;
        endcase
        dec.br_pol = (opcode == BEQ) || (opcode == BCS) || (opcode == BMI);
    end

endmodule

/* hdl/fc8_alu.sv */
// Combinational ALU with N, Z and C outputs
`timescale 1ns/1ps

module fc8_alu (
    input  fc8_pkg::alu_op_e op,
    input  fc8_pkg::byte_t   lhs,
    input  fc8_pkg::byte_t   rhs,
    input  logic             carry_in,
    output fc8_pkg::byte_t   result,
    output fc8_pkg::flags_t  flags
);
    import fc8_pkg::*;

    logic [8:0] sum;    // Bit 8 is carry out
    logic [8:0] diff;   // Bit 8 is borrow
    logic       c_out;

    assign sum  = {1'b0, lhs} + {1'b0, rhs} + {8'h00, carry_in};
    assign diff = {1'b0, lhs} - {1'b0, rhs} - {8'h00, ~carry_in};

    always_comb begin
        c_out = carry_in;
        case (op)
            ALU_ADD: begin
                result = sum[7:0];
                c_out  = sum[8];
            end
            ALU_SUB: begin
                result = diff[7:0];
                c_out  = ~diff[8];   // Set when no borrow
            end
            ALU_CMP: begin
                result = lhs - rhs;
                c_out  = (lhs >= rhs);
            end
            ALU_AND: result = lhs & rhs;
            ALU_OR:  result = lhs | rhs;
            ALU_XOR: result = lhs ^ rhs;
            ALU_INC: result = lhs + 8'd1;
            ALU_DEC: result = lhs - 8'd1;
            default: result = rhs;   // Loads pass the operand through
        endcase
    end

    assign flags.n = result[7];
    assign flags.z = (result == 8'h00);
    assign flags.c = c_out;

endmodule

/* hdl/fc8_regs.sv */
// A, X and flag registers with writeback and store-data select
`timescale 1ns/1ps

module fc8_regs (
    input logic      clk,
    input logic      rst_n,
    fc8_exec_if.regs ex
);
    import fc8_pkg::*;

    byte_t  a;
    byte_t  x;
    flags_t flags;

    byte_t  alu_lhs;
    byte_t  alu_result;
    flags_t alu_flags;
    logic   upd_flags;

    assign alu_lhs = ex.dec.lhs_x ? x : a;

    fc8_alu u_alu (
        .op       (ex.dec.alu_op),
        .lhs      (alu_lhs),
        .rhs      (ex.operand),
        .carry_in (flags.c),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    // Writes and compares touch the flags, NOP leaves them alone
    assign upd_flags = (ex.dec.dest != DEST_NONE) || (ex.dec.alu_op == ALU_CMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a     <= '0;
            x     <= '0;
            flags <= '0;
        end else if (ex.exec) begin
            case (ex.dec.dest)
                DEST_A:  a <= alu_result;
                DEST_X:  x <= alu_result;
                default: ;
            endcase
            if (ex.dec.flag_set) begin
                flags.c <= ex.dec.flag_val;   // CLC and SEC
            end else if (upd_flags) begin
                flags <= alu_flags;
            end
        end
    end

    assign ex.flags      = flags;
    assign ex.store_data = ex.dec.store_x ? x : a;

    // Stores go straight to memory and never reach writeback
    a_no_store_writeback: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex.exec |-> !(ex.dec.dest == DEST_X && ex.dec.flow == FLOW_STORE)
    ) else $error("exec with store flow and X destination");

endmodule

/* hdl/fc8_sequencer.sv */
// Instruction sequencer FSM with program counter and memory strobes
`timescale 1ns/1ps

module fc8_sequencer #(
    parameter fc8_pkg::addr_t RESET_VECTOR = fc8_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic           clk,
    input  logic           rst_n,
    fc8_exec_if.seq        ex,
    output fc8_pkg::addr_t mem_addr,
    output logic           mem_rd_en,
    output logic           mem_wr_en,
    output fc8_pkg::byte_t mem_wdata,
    input  fc8_pkg::byte_t mem_rdata,
    output logic           halted
);
    import fc8_pkg::*;

    typedef enum logic [3:0] {
        S_VEC_LO,
        S_VEC_HI,
        S_FETCH,
        S_DECODE,
        S_OPERAND,
        S_ADDR_HI,
        S_READ,
        S_WRITE,
        S_BRANCH,
        S_HALT
    } state_e;

    state_e   state;
    state_e   state_nxt;
    addr_t    pc;
    addr_t    pc_nxt;
    addr_t    ea;           // Effective address
    byte_t    opcode;
    byte_t    dec_opcode;
    decoded_t dec;
    logic     taken;

    // Opcode byte is still on the bus while decoding
    assign dec_opcode = (state == S_DECODE) ? mem_rdata : opcode;

    fc8_decoder u_dec (
        .opcode (dec_opcode),
        .dec    (dec)
    );

    assign ex.dec     = dec;
    assign ex.operand = mem_rdata;
    assign taken      = (ex.flags[dec.br_sel] == dec.br_pol);

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        mem_addr  = pc;
        mem_rd_en = 1'b0;
        mem_wr_en = 1'b0;
        mem_wdata = '0;
        ex.exec   = 1'b0;
        case (state)
            S_VEC_LO: begin
                mem_addr  = RESET_VECTOR;
                mem_rd_en = 1'b1;
                state_nxt = S_VEC_HI;
            end
            S_VEC_HI: begin
                mem_addr  = RESET_VECTOR + 16'd1;
                mem_rd_en = 1'b1;
                state_nxt = S_ADDR_HI;   // Reset opcode is JMP
            end
            S_FETCH: begin
                mem_rd_en = 1'b1;
                pc_nxt    = pc + 16'd1;
                state_nxt = S_DECODE;
            end
            S_DECODE: begin
                if (dec.mode != MODE_NONE) begin
                    mem_rd_en = 1'b1;    // First operand byte
                    pc_nxt    = pc + 16'd1;
                end
                if (dec.flow == FLOW_HALT) begin
                    state_nxt = S_HALT;
                end else if (dec.flow == FLOW_BRANCH) begin
                    state_nxt = S_BRANCH;
                end else begin
                    state_nxt = S_OPERAND;
                end
            end
            S_OPERAND: begin
                case (dec.mode)
                    MODE_ZP: begin
                        if (dec.flow == FLOW_STORE) begin
                            state_nxt = S_WRITE;
                        end else begin
                            mem_addr  = {8'h00, mem_rdata};
                            mem_rd_en = 1'b1;
                            state_nxt = S_READ;
                        end
                    end
                    MODE_ABS: begin
                        mem_rd_en = 1'b1;  // High address byte
                        pc_nxt    = pc + 16'd1;
                        state_nxt = S_ADDR_HI;
                    end
                    default: begin
                        ex.exec   = 1'b1;  // Implied and immediate
                        state_nxt = S_FETCH;
                    end
                endcase
            end
            S_ADDR_HI: begin
                case (dec.flow)
                    FLOW_JUMP: begin
                        pc_nxt    = {mem_rdata, ea[7:0]};
                        state_nxt = S_FETCH;
                    end
                    FLOW_STORE: state_nxt = S_WRITE;
                    default: begin
                        mem_addr  = {mem_rdata, ea[7:0]};
                        mem_rd_en = 1'b1;
                        state_nxt = S_READ;
                    end
                endcase
            end
            S_READ: begin
                ex.exec   = 1'b1;
                state_nxt = S_FETCH;
            end
            S_WRITE: begin
                mem_addr  = ea;
                mem_wr_en = 1'b1;
                mem_wdata = ex.store_data;
                state_nxt = S_FETCH;
            end
            S_BRANCH: begin
                if (taken) begin
                    pc_nxt = pc + {{8{mem_rdata[7]}}, mem_rdata};
                end
                state_nxt = S_FETCH;
            end
            S_HALT: begin
                if (!halted) begin
                    state_nxt = S_VEC_LO;  // Leaving reset
                end
            end
            default: state_nxt = S_VEC_LO;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_HALT;
            pc     <= '0;
            opcode <= JMP;
            halted <= 1'b0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
            if (state == S_DECODE) begin
                opcode <= mem_rdata;
                if (dec.flow == FLOW_HALT) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_VEC_HI || (state == S_OPERAND && dec.mode == MODE_ABS)) begin
            ea[7:0] <= mem_rdata;
        end
        if (state == S_OPERAND && dec.mode == MODE_ZP) begin
            ea <= {8'h00, mem_rdata};
        end
        if (state == S_ADDR_HI) begin
            ea[15:8] <= mem_rdata;
        end
    end

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_rd_en && mem_wr_en)
    ) else $error("read and write strobes high together");

    a_halt_is_final: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted && !ex.exec && !mem_rd_en && !mem_wr_en
    ) else $error("activity after halt");

endmodule

/* hdl/fc8_cpu.sv */
// CPU top level with sequencer, register block and memory port
`timescale 1ns/1ps

module fc8_cpu #(
    parameter fc8_pkg::addr_t RESET_VECTOR = fc8_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic           clk,
    input  logic           rst_n,
    output fc8_pkg::addr_t mem_addr,
    output logic           mem_rd_en,
    output logic           mem_wr_en,
    output fc8_pkg::byte_t mem_wdata,
    input  fc8_pkg::byte_t mem_rdata,
    output logic           halted
);

    fc8_exec_if u_ex ();

    fc8_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex        (u_ex),
        .mem_addr  (mem_addr),
        .mem_rd_en (mem_rd_en),
        .mem_wr_en (mem_wr_en),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    fc8_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .ex    (u_ex)
    );

endmodule

/* test/fc8_tb_mem.sv */
// Behavioural 64 KB memory with synchronous read and a write log
`timescale 1ns/1ps

module fc8_tb_mem (
    input  logic           clk,
    input  fc8_pkg::addr_t addr,
    input  logic           rd_en,
    input  logic           wr_en,
    input  fc8_pkg::byte_t wdata,
    output fc8_pkg::byte_t rdata
);
    import fc8_pkg::*;

    localparam int LOG_DEPTH = 64;

    byte_t mem [0:65535];
    byte_t rdata_q = 8'h00;
    addr_t log_addr [0:LOG_DEPTH-1];
    byte_t log_data [0:LOG_DEPTH-1];
    int    log_count = 0;

    assign rdata = rdata_q;

    always @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= mem[addr];  // Data shows up one cycle later
        end
        if (wr_en) begin
            mem[addr] = wdata;
            if (log_count < LOG_DEPTH) begin
                log_addr[log_count] = addr;
                log_data[log_count] = wdata;
            end
            log_count = log_count + 1;
        end
    end

    task automatic clear_all();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'h00;
        end
        log_count = 0;
    endtask

    task automatic poke(input addr_t a, input byte_t d);
        mem[a] = d;
    endtask

endmodule

/* test/fc8_tb.sv */
// Testbench top that reads tests, loads programs, runs them and checks memory writes
`timescale 1ns/1ps

module fc8_tb;
    import fc8_pkg::*;

    localparam int    HALF_PERIOD  = 50;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    RESET_CYCLES = 8;
    localparam int    HALT_TIMEOUT = 2000;
    localparam int    QUIET_CYCLES = 20;
    localparam int    FILL_BYTES   = 16;
    localparam int    MAX_BYTES    = 64;
    localparam int    MAX_WRITES   = 16;
    localparam int    SEED         = 11;
    localparam addr_t PROG_BASE    = 16'h0200;

    logic  clk;
    logic  rst_n;
    addr_t mem_addr;
    logic  mem_rd_en;
    logic  mem_wr_en;
    byte_t mem_wdata;
    byte_t mem_rdata;
    logic  halted;

    string test_name;
    int    n_prog;
    int    n_wr;
    byte_t prog [0:MAX_BYTES-1];
    addr_t exp_addr [0:MAX_WRITES-1];
    byte_t exp_data [0:MAX_WRITES-1];
    int    tests_run;

    fc8_cpu u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_rd_en (mem_rd_en),
        .mem_wr_en (mem_wr_en),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    fc8_tb_mem u_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .rd_en (mem_rd_en),
        .wr_en (mem_wr_en),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_value(input string what, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("FAIL %s %s: expected %h, actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Each test holds name, byte count, program bytes, write count and address/value pairs
    task automatic read_test(input int fd, output bit found);
        string tok;
        string rest;
        int    code;
        int    value;
        int    wa;
        int    i;
        found = 1'b0;
        code = $fscanf(fd, "%s", tok);
        while (code == 1 && tok.substr(0, 0) == "#") begin
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", tok);
        end
        if (code == 1) begin
            test_name = tok;
            code = $fscanf(fd, "%d", n_prog);
            if (code != 1 || n_prog < 1 || n_prog > MAX_BYTES) begin
                stop_run($sformatf("test %s has a bad program length", test_name));
            end
            for (i = 0; i < n_prog; i++) begin
                code = $fscanf(fd, "%h", value);
                if (code != 1) begin
                    stop_run($sformatf("test %s has a missing program byte", test_name));
                end
                prog[i] = byte_t'(value);
            end
            code = $fscanf(fd, "%d", n_wr);
            if (code != 1 || n_wr < 0 || n_wr > MAX_WRITES) begin
                stop_run($sformatf("test %s has a bad write count", test_name));
            end
            for (i = 0; i < n_wr; i++) begin
                code = $fscanf(fd, "%h %h", wa, value);
                if (code != 2) begin
                    stop_run($sformatf("test %s has a missing expected write", test_name));
                end
                exp_addr[i] = addr_t'(wa);
                exp_data[i] = byte_t'(value);
            end
            found = 1'b1;
        end
    endtask

    task automatic load_program();
        int i;
        u_mem.clear_all();
        for (i = 0; i < FILL_BYTES; i++) begin
            u_mem.poke(addr_t'(PROG_BASE - FILL_BYTES + i), byte_t'($urandom));
            u_mem.poke(addr_t'(PROG_BASE + n_prog + i), byte_t'($urandom));
        end
        for (i = 0; i < n_prog; i++) begin
            u_mem.poke(addr_t'(PROG_BASE + i), prog[i]);
        end
        u_mem.poke(RESET_VECTOR_DEFAULT, PROG_BASE[7:0]);
        u_mem.poke(RESET_VECTOR_DEFAULT + 16'd1, PROG_BASE[15:8]);
    endtask

    task automatic run_test();
        int cycles;
        int i;
        step_cycle();
        rst_n = 1'b0;
        load_program();
        repeat (RESET_CYCLES) step_cycle();
        compare_value("halted in reset", 16'h0000, 16'(halted));
        compare_value("read strobe in reset", 16'h0000, 16'(mem_rd_en));
        compare_value("write strobe in reset", 16'h0000, 16'(mem_wr_en));
        rst_n = 1'b1;
        cycles = 0;
        while (!halted) begin
            if (cycles == HALT_TIMEOUT) begin
                stop_run($sformatf("test %s timed out waiting for halt", test_name));
            end
            step_cycle();
            cycles++;
        end
        for (i = 0; i < QUIET_CYCLES; i++) begin  // No reads or writes may follow HLT
            step_cycle();
            compare_value("read strobe after halt", 16'h0000, 16'(mem_rd_en));
        end
        compare_value("halted after window", 16'h0001, 16'(halted));
        if (u_mem.log_count != n_wr) begin
            stop_run($sformatf("test %s saw %0d memory writes but expected %0d",
                               test_name, u_mem.log_count, n_wr));
        end
        for (i = 0; i < n_wr; i++) begin
            compare_value($sformatf("write %0d address", i), exp_addr[i], u_mem.log_addr[i]);
            compare_value($sformatf("write %0d data", i), 16'(exp_data[i]),
                          16'(u_mem.log_data[i]));
        end
        $display("%s: %0d writes checked", test_name, n_wr);
    endtask

    initial begin
        int fd;
        bit found;
        rst_n = 1'b0;
        tests_run = 0;
        void'($urandom(SEED));
        fd = $fopen("test/fc8_tests.txt", "r");
        if (fd == 0) begin
            stop_run("could not open test/fc8_tests.txt");
        end
        read_test(fd, found);
        while (found) begin
            run_test();
            tests_run++;
            read_test(fd, found);
        end
        $fclose(fd);
        if (tests_run > 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run("no tests were read from the test file");
        end
    end

endmodule

/* test/fc8_tests.txt */
# name  n_bytes  program bytes (hex, loaded at 0200)
# n_writes  expected writes in order as address value pairs (hex)
reset_vector 5 A9 5A 85 10 02 1 0010 5A
lda_sta 10 A9 11 85 20 A9 22 8D 00 04 02 2 0020 11 0400 22
zp_readback 12 A9 33 85 30 A9 00 A5 30 8D 10 04 02 2 0030 33 0410 33
abs_readback 13 A9 44 8D 20 04 A9 00 AD 20 04 85 31 02 2 0420 44 0031 44
ldx_stx 17 A2 55 86 40 A2 00 A6 40 E8 86 41 AE 01 02 86 42 02 3 0040 55 0041 56 0042 55
adc16 14 18 A9 F0 69 34 85 50 A9 12 69 01 85 51 02 2 0050 24 0051 14
adc_modes 15 A9 05 85 60 38 A9 10 65 60 6D 60 00 85 61 02 2 0060 05 0061 1B
sbc16 14 38 A9 34 E9 56 85 70 A9 12 E9 01 85 71 02 2 0070 DE 0071 10
sbc_modes 15 A9 03 85 72 38 A9 10 E5 72 ED 72 00 85 73 02 2 0072 03 0073 0A
logic_imm 15 A9 F0 29 3C 85 80 09 0F 85 81 49 FF 85 82 02 3 0080 30 0081 3F 0082 C0
logic_mem 18 A9 0F 85 83 A9 3C 25 83 85 84 09 F0 4D 83 00 85 85 02 3 0083 0F 0084 0C 0085 F3
inx_dex_wrap 12 A2 FE E8 86 90 E8 86 91 CA 86 92 02 3 0090 FF 0091 00 0092 FF
beq 19 A2 77 A9 40 C9 40 F0 02 85 A0 86 A1 C9 41 F0 02 85 A2 02 2 00A1 77 00A2 40
bne 19 A2 66 A9 40 C9 41 D0 02 85 A0 86 A1 C9 40 D0 02 85 A2 02 2 00A1 66 00A2 40
bcc 19 A2 55 A9 40 C9 50 90 02 85 A0 86 A1 C9 30 90 02 85 A2 02 2 00A1 55 00A2 40
bcs 17 A2 44 A9 40 38 B0 02 85 A0 86 A1 18 B0 02 85 A2 02 2 00A1 44 00A2 40
bmi 17 A2 33 A9 90 30 02 85 A0 86 A1 A9 10 30 02 85 A2 02 2 00A1 33 00A2 10
bpl 17 A2 22 A9 10 10 02 85 A0 86 A1 A9 F0 10 02 85 A2 02 2 00A1 22 00A2 F0
cmp_modes 22 A2 99 A9 40 85 D0 C5 D0 F0 02 85 D1 CD 01 02 90 02 85 D2 86 D3 02 2 00D0 40 00D3 99
dex_loop 15 A2 05 A9 00 18 69 01 CA D0 FA 85 B0 86 B1 02 2 00B0 05 00B1 00
jmp_skip 15 A9 12 4C 07 02 85 C0 85 C1 4C 0E 02 85 C2 02 1 00C1 12
nop_unknown 10 A9 3C FF EA 1A 85 E0 02 85 E1 1 00E0 3C

/* sim.f */
hdl/fc8_pkg.sv
hdl/fc8_exec_if.sv
hdl/fc8_decoder.sv
hdl/fc8_alu.sv
hdl/fc8_regs.sv
hdl/fc8_sequencer.sv
hdl/fc8_cpu.sv
test/fc8_tb_mem.sv
test/fc8_tb.sv
